// File: hps_io_defs.svh
// hps word port constants
// widths, counts and the download address step

`ifndef HPS_IO_DEFS_SVH
`define HPS_IO_DEFS_SVH

// host word bus
`define HPS_DW          16
// saturating word counter
`define HPS_CNT_W       4

// user command unit
`define HPS_NUM_JOY     6
`define HPS_STATUS_W    64
`define HPS_ST_TAG      4'hA

// file transfer unit
`define HPS_ADDR_W      27
`define HPS_ADDR_STEP   2
`define HPS_UPLOAD_KEY  16'h00AA

`endif

// File: hps_io_pkg.sv
// hps word port types
// opcodes of both command units and the bus owner encoding

`include "hps_io_defs.svh"

package hps_io_pkg;

	// user commands
	typedef enum logic [`HPS_DW-1:0] {
		CFG        = 16'h0001,
		JOY0       = 16'h0002,
		JOY1       = 16'h0003,
		JOY_RAW    = 16'h000F,
		JOY2       = 16'h0010,
		JOY3       = 16'h0011,
		JOY4       = 16'h0012,
		JOY5       = 16'h0013,
		STATUS     = 16'h001E,
		STATUS_REQ = 16'h0029,
		MENU_MASK  = 16'h002E
	} uio_cmd_e;

	// file transfer commands
	typedef enum logic [`HPS_DW-1:0] {
		FILE_TX     = 16'h0053,
		FILE_TX_DAT = 16'h0054,
		FILE_INDEX  = 16'h0055,
		FILE_INFO   = 16'h0056
	} fio_cmd_e;

	typedef enum logic [1:0] {
		NONE = 2'd0,
		USER = 2'd1,
		FILE = 2'd2
	} bus_owner_e;

endpackage

// File: hps_word_if.sv
// one peer's view of the framed host word bus
// the frame side drives the word stream, the peer answers with a reply word

`timescale 1ns/1ns

`include "hps_io_defs.svh"

interface hps_word_if;

	// one cycle per host word
	logic                  strobe;
	// command word of the frame
	logic                  first;
	logic [`HPS_DW-1:0]    cmd;
	// argument index, zero on the first argument
	logic [`HPS_CNT_W-1:0] word_cnt;
	logic [`HPS_DW-1:0]    din;
	// registered reply
	logic [`HPS_DW-1:0]    dout;
	// peer owns the current frame
	logic                  open;

	modport frame (
		output strobe, first, cmd, word_cnt, din, open,
		input  dout
	);

	modport peer (
		input  strobe, first, cmd, word_cnt, din, open,
		output dout
	);

endinterface

// File: hps_bus_frame.sv
// frame arbiter for the host word bus
// grants each frame to one peer, captures the command and counts the words

`timescale 1ns/1ns

`include "hps_io_defs.svh"

module hps_bus_frame (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               io_enable,
	input  logic               fp_enable,
	input  logic               io_strobe,
	input  logic [`HPS_DW-1:0] io_din,
	output logic [`HPS_DW-1:0] io_dout,
	hps_word_if.frame          uio_bus,
	hps_word_if.frame          fio_bus
);

	hps_io_pkg::bus_owner_e owner_q;
	hps_io_pkg::bus_owner_e owner_new;
	hps_io_pkg::bus_owner_e owner_cur;
	logic                   owner_live;
	logic                   has_cmd;
	logic [`HPS_DW-1:0]     cmd_q;
	logic [`HPS_CNT_W-1:0]  cnt_q;

	////////////////////////////////////////////////////////////////////////////
	// ownership
	////////////////////////////////////////////////////////////////////////////

	// file transfers win when both enables rise together
	assign owner_new = fp_enable ? hps_io_pkg::FILE :
		io_enable ? hps_io_pkg::USER : hps_io_pkg::NONE;

	assign owner_live = (owner_q == hps_io_pkg::FILE && fp_enable) ||
		(owner_q == hps_io_pkg::USER && io_enable);

	// grant is usable on the first cycle of a frame
	assign owner_cur = (owner_q == hps_io_pkg::NONE) ? owner_new :
		owner_live ? owner_q : hps_io_pkg::NONE;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			owner_q <= hps_io_pkg::NONE;
			has_cmd <= 1'b0;
			cmd_q   <= '0;
			cnt_q   <= '0;
		end else begin
			if (owner_q == hps_io_pkg::NONE)
				owner_q <= owner_new;
			// no new grant until the bus has gone idle
			else if (!io_enable && !fp_enable)
				owner_q <= hps_io_pkg::NONE;

			if (owner_cur == hps_io_pkg::NONE) begin
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					cmd_q   <= io_din;
					has_cmd <= 1'b1;
					cnt_q   <= '0;
				end else if (~&cnt_q) begin
					cnt_q <= cnt_q + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// word routing
	////////////////////////////////////////////////////////////////////////////

	assign uio_bus.open     = (owner_cur == hps_io_pkg::USER);
	assign uio_bus.strobe   = io_strobe && uio_bus.open;
	assign uio_bus.first    = uio_bus.open && !has_cmd;
	assign uio_bus.cmd      = cmd_q;
	assign uio_bus.word_cnt = cnt_q;
	assign uio_bus.din      = io_din;

	assign fio_bus.open     = (owner_cur == hps_io_pkg::FILE);
	assign fio_bus.strobe   = io_strobe && fio_bus.open;
	assign fio_bus.first    = fio_bus.open && !has_cmd;
	assign fio_bus.cmd      = cmd_q;
	assign fio_bus.word_cnt = cnt_q;
	assign fio_bus.din      = io_din;

	// reply of the current owner only
	always_comb begin
		case (owner_cur)
			hps_io_pkg::USER: io_dout = uio_bus.dout;
			hps_io_pkg::FILE: io_dout = fio_bus.dout;
			default:          io_dout = '0;
		endcase
	end

endmodule

// File: uio_regs.sv
// user command unit
// config word, joysticks, status and the status-set request

`timescale 1ns/1ns

`include "hps_io_defs.svh"

module uio_regs (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	hps_word_if.peer                 bus,
	output logic [31:0]              joystick_0,
	output logic [31:0]              joystick_1,
	output logic [31:0]              joystick_2,
	output logic [31:0]              joystick_3,
	output logic [31:0]              joystick_4,
	output logic [31:0]              joystick_5,
	output logic [1:0]               buttons,
	output logic                     forced_scandoubler,
	output logic                     direct_video,
	output logic [`HPS_STATUS_W-1:0] status,
	input  logic [`HPS_STATUS_W-1:0] status_in,
	input  logic                     status_set,
	input  logic [`HPS_DW-1:0]       status_menumask,
	input  logic [`HPS_DW-1:0]       joy_raw
);

	localparam int JOY_IDX_W = $clog2(`HPS_NUM_JOY);

	logic [`HPS_DW-1:0]        cfg;
	logic [31:0]               joy [`HPS_NUM_JOY];
	logic [JOY_IDX_W-1:0]      joy_idx;
	logic                      joy_hit;
	logic                      act;
	logic                      st_old;
	logic [3:0]                st_cnt;
	logic [`HPS_STATUS_W-1:0]  st_req;

	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	assign joystick_0 = joy[0];
	assign joystick_1 = joy[1];
	assign joystick_2 = joy[2];
	assign joystick_3 = joy[3];
	assign joystick_4 = joy[4];
	assign joystick_5 = joy[5];

	assign act = bus.open && bus.strobe;

	// joystick opcodes are not contiguous
	always_comb begin
		joy_hit = 1'b1;
		joy_idx = '0;
		case (bus.cmd)
			hps_io_pkg::JOY0: joy_idx = JOY_IDX_W'(0);
			hps_io_pkg::JOY1: joy_idx = JOY_IDX_W'(1);
			hps_io_pkg::JOY2: joy_idx = JOY_IDX_W'(2);
			hps_io_pkg::JOY3: joy_idx = JOY_IDX_W'(3);
			hps_io_pkg::JOY4: joy_idx = JOY_IDX_W'(4);
			hps_io_pkg::JOY5: joy_idx = JOY_IDX_W'(5);
			default:          joy_hit = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// status-set request
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			st_old <= 1'b0;
			st_cnt <= '0;
		end else begin
			st_old <= status_set;
			if (status_set && !st_old)
				st_cnt <= st_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_set && !st_old)
			st_req <= status_in;
	end

	////////////////////////////////////////////////////////////////////////////
	// command decode
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cfg      <= '0;
			status   <= '0;
			bus.dout <= '0;
			for (int j = 0; j < `HPS_NUM_JOY; j++)
				joy[j] <= '0;
		end else if (act) begin
			bus.dout <= '0;
			if (bus.first) begin
				// tag and request count in one byte
				if (bus.din == hps_io_pkg::STATUS_REQ)
					bus.dout <= {8'h00, `HPS_ST_TAG, st_cnt};
			end else begin
				case (bus.cmd)
					hps_io_pkg::CFG:
						cfg <= bus.din;
					hps_io_pkg::STATUS:
						if (bus.word_cnt < 4)
							status[{bus.word_cnt[1:0], 4'b0000} +: 16] <= bus.din;
					hps_io_pkg::STATUS_REQ:
						if (bus.word_cnt < 4)
							bus.dout <= st_req[{bus.word_cnt[1:0], 4'b0000} +: 16];
					hps_io_pkg::JOY_RAW:
						bus.dout <= joy_raw;
					hps_io_pkg::MENU_MASK:
						if (bus.word_cnt == 0)
							bus.dout <= status_menumask;
					default: ;
				endcase
				// low half first
				if (joy_hit) begin
					if (bus.word_cnt == 0)
						joy[joy_idx][15:0] <= bus.din;
					else if (bus.word_cnt == 1)
						joy[joy_idx][31:16] <= bus.din;
				end
			end
		end
	end

endmodule

// File: fio_loader.sv
// file transfer unit
// index and extension, download write pulses and upload read pulses

`timescale 1ns/1ns

`include "hps_io_defs.svh"

module fio_loader (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	hps_word_if.peer               bus,
	output logic                   ioctl_download,
	output logic                   ioctl_upload,
	output logic [`HPS_DW-1:0]     ioctl_index,
	output logic [31:0]            ioctl_file_ext,
	output logic                   ioctl_wr,
	output logic                   ioctl_rd,
	output logic [`HPS_ADDR_W-1:0] ioctl_addr,
	output logic [`HPS_DW-1:0]     ioctl_dout,
	input  logic [`HPS_DW-1:0]     ioctl_din
);

	logic                   act;
	logic                   arg;
	logic                   is_tx;
	logic                   is_dat;
	logic                   tx_up;
	logic                   tx_dn;
	logic                   tx_stop;
	logic                   dat_wr;
	logic                   dat_rd;
	logic                   wr_pend;
	logic [`HPS_ADDR_W-1:0] addr_nxt;

	assign act    = bus.open && bus.strobe;
	assign arg    = act && !bus.first;
	assign is_tx  = arg && (bus.cmd == hps_io_pkg::FILE_TX);
	assign is_dat = arg && (bus.cmd == hps_io_pkg::FILE_TX_DAT);

	// first FILE_TX argument selects the transfer
	assign tx_up   = is_tx && bus.word_cnt == 0 && bus.din == `HPS_UPLOAD_KEY;
	assign tx_stop = is_tx && bus.word_cnt == 0 && bus.din == '0;
	assign tx_dn   = is_tx && bus.word_cnt == 0 && !tx_up && !tx_stop;

	assign dat_wr = is_dat && ioctl_download;
	assign dat_rd = is_dat && ioctl_upload && !ioctl_download;

	////////////////////////////////////////////////////////////////////////////
	// transfer control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ioctl_download <= 1'b0;
			ioctl_upload   <= 1'b0;
			wr_pend        <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_rd       <= 1'b0;
			bus.dout       <= '0;
		end else begin
			// write lands one cycle after the address and data
			wr_pend  <= dat_wr;
			ioctl_wr <= wr_pend;
			ioctl_rd <= tx_up || dat_rd;
			if (tx_up)
				ioctl_upload <= 1'b1;
			if (tx_dn)
				ioctl_download <= 1'b1;
			if (tx_stop) begin
				ioctl_download <= 1'b0;
				ioctl_upload   <= 1'b0;
			end
			if (act)
				bus.dout <= dat_rd ? ioctl_din : '0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// address, data and file info
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (tx_up)
			ioctl_addr <= '0;
		if (tx_dn)
			addr_nxt <= '0;
		// park on the next download address
		if (tx_stop && ioctl_download)
			ioctl_addr <= addr_nxt;
		if (is_tx && bus.word_cnt == 1) begin
			ioctl_addr[15:0] <= bus.din;
			addr_nxt[15:0]   <= bus.din;
		end
		if (is_tx && bus.word_cnt == 2) begin
			ioctl_addr[`HPS_ADDR_W-1:16] <= bus.din[`HPS_ADDR_W-17:0];
			addr_nxt[`HPS_ADDR_W-1:16]   <= bus.din[`HPS_ADDR_W-17:0];
		end
		if (dat_wr) begin
			ioctl_addr <= addr_nxt;
			ioctl_dout <= bus.din;
			addr_nxt   <= addr_nxt + `HPS_ADDR_W'(`HPS_ADDR_STEP);
		end
		if (dat_rd)
			ioctl_addr <= ioctl_addr + `HPS_ADDR_W'(`HPS_ADDR_STEP);
		if (arg && bus.cmd == hps_io_pkg::FILE_INDEX)
			ioctl_index <= bus.din;
		// extension arrives high half first
		if (arg && bus.cmd == hps_io_pkg::FILE_INFO) begin
			if (bus.word_cnt == 0)
				ioctl_file_ext[31:16] <= bus.din;
			else if (bus.word_cnt == 1)
				ioctl_file_ext[15:0] <= bus.din;
		end
	end

endmodule

// File: hps_io.sv
// hps word port top level
// arbiter plus user and file command units on plain ports

`timescale 1ns/1ns

`include "hps_io_defs.svh"

module hps_io (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     io_enable,
	input  logic                     fp_enable,
	input  logic                     io_strobe,
	input  logic [`HPS_DW-1:0]       io_din,
	output logic [`HPS_DW-1:0]       io_dout,
	// user side
	output logic [31:0]              joystick_0,
	output logic [31:0]              joystick_1,
	output logic [31:0]              joystick_2,
	output logic [31:0]              joystick_3,
	output logic [31:0]              joystick_4,
	output logic [31:0]              joystick_5,
	output logic [1:0]               buttons,
	output logic                     forced_scandoubler,
	output logic                     direct_video,
	output logic [`HPS_STATUS_W-1:0] status,
	input  logic [`HPS_STATUS_W-1:0] status_in,
	input  logic                     status_set,
	input  logic [`HPS_DW-1:0]       status_menumask,
	input  logic [`HPS_DW-1:0]       joy_raw,
	// file side
	output logic                     ioctl_download,
	output logic                     ioctl_upload,
	output logic [`HPS_DW-1:0]       ioctl_index,
	output logic [31:0]              ioctl_file_ext,
	output logic                     ioctl_wr,
	output logic                     ioctl_rd,
	output logic [`HPS_ADDR_W-1:0]   ioctl_addr,
	output logic [`HPS_DW-1:0]       ioctl_dout,
	input  logic [`HPS_DW-1:0]       ioctl_din
);

	hps_word_if uio_bus ();
	hps_word_if fio_bus ();

	hps_bus_frame u_frame (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.io_enable (io_enable),
		.fp_enable (fp_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.io_dout   (io_dout),
		.uio_bus   (uio_bus.frame),
		.fio_bus   (fio_bus.frame)
	);

	uio_regs u_uio (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.bus                (uio_bus.peer),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_2         (joystick_2),
		.joystick_3         (joystick_3),
		.joystick_4         (joystick_4),
		.joystick_5         (joystick_5),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.status             (status),
		.status_in          (status_in),
		.status_set         (status_set),
		.status_menumask    (status_menumask),
		.joy_raw            (joy_raw)
	);

	fio_loader u_fio (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.bus            (fio_bus.peer),
		.ioctl_download (ioctl_download),
		.ioctl_upload   (ioctl_upload),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_wr       (ioctl_wr),
		.ioctl_rd       (ioctl_rd),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_din      (ioctl_din)
	);

endmodule

// File: tb_hps_io.sv
// testbench for the hps word port
// drives host frames on the word bus and checks both command units

`timescale 1ns/1ns

`include "hps_io_defs.svh"

module tb_hps_io;

	localparam int clk_period = 100;
	localparam int n_dl       = 24;
	localparam int n_ul       = 12;
	// all words of all frames including command words
	localparam int n_words    = 56 + n_dl + n_ul;
	localparam int margin     = 200;

	localparam logic [15:0] joy_ops [6] = '{
		hps_io_pkg::JOY0, hps_io_pkg::JOY1, hps_io_pkg::JOY2,
		hps_io_pkg::JOY3, hps_io_pkg::JOY4, hps_io_pkg::JOY5
	};

	logic        clk_sys;
	logic        rst_n;
	logic        io_enable;
	logic        fp_enable;
	logic        io_strobe;
	logic [15:0] io_din;
	logic [15:0] io_dout;
	logic [31:0] joystick_0;
	logic [31:0] joystick_1;
	logic [31:0] joystick_2;
	logic [31:0] joystick_3;
	logic [31:0] joystick_4;
	logic [31:0] joystick_5;
	logic [1:0]  buttons;
	logic        forced_scandoubler;
	logic        direct_video;
	logic [63:0] status;
	logic [63:0] status_in;
	logic        status_set;
	logic [15:0] status_menumask;
	logic [15:0] joy_raw;
	logic        ioctl_download;
	logic        ioctl_upload;
	logic [15:0] ioctl_index;
	logic [31:0] ioctl_file_ext;
	logic        ioctl_wr;
	logic        ioctl_rd;
	logic [26:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic [15:0] ioctl_din;

	logic [31:0] lfsr_state = 32'he45a;
	logic [15:0] tx_words [$];
	logic [15:0] rx_words [$];
	logic [26:0] wr_addr_exp [$];
	logic [15:0] wr_data_exp [$];
	int          wr_cnt = 0;
	int          rd_cnt = 0;

	hps_io u_hps_io (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.io_enable          (io_enable),
		.fp_enable          (fp_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_2         (joystick_2),
		.joystick_3         (joystick_3),
		.joystick_4         (joystick_4),
		.joystick_5         (joystick_5),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.status             (status),
		.status_in          (status_in),
		.status_set         (status_set),
		.status_menumask    (status_menumask),
		.joy_raw            (joy_raw),
		.ioctl_download     (ioctl_download),
		.ioctl_upload       (ioctl_upload),
		.ioctl_index        (ioctl_index),
		.ioctl_file_ext     (ioctl_file_ext),
		.ioctl_wr           (ioctl_wr),
		.ioctl_rd           (ioctl_rd),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout),
		.ioctl_din          (ioctl_din)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(clk_period * (n_words * 4 + margin));
		fail_now("watchdog timeout: the tests did not finish in time");
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got == exp)
		else fail_now($sformatf("error %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// galois lfsr stepped once per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			else
				lfsr_state = lfsr_state >> 1;
			value = {value[62:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// every address bit changes the word
	function automatic logic [15:0] mem_word(input logic [26:0] addr);
		return {addr[7:0], addr[15:8]} ^ {5'b0, addr[26:16]} ^ 16'h3c5a;
	endfunction

	function automatic logic [31:0] joy_out(input int n);
		case (n)
			0:       return joystick_0;
			1:       return joystick_1;
			2:       return joystick_2;
			3:       return joystick_3;
			4:       return joystick_4;
			default: return joystick_5;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// host side
	////////////////////////////////////////////////////////////////////////////

	task automatic send_word(input logic [15:0] data, output logic [15:0] reply);
		@(posedge clk_sys);
		io_strobe <= 1'b1;
		io_din    <= data;
		@(posedge clk_sys);
		io_strobe <= 1'b0;
		@(negedge clk_sys);
		reply = io_dout;
	endtask

	// sends tx_words as one frame and collects the replies in rx_words
	task automatic run_frame(input logic file_en, input logic user_en);
		logic [15:0] reply;
		rx_words.delete();
		@(posedge clk_sys);
		fp_enable <= file_en;
		io_enable <= user_en;
		foreach (tx_words[i]) begin
			send_word(tx_words[i], reply);
			rx_words.push_back(reply);
		end
		@(posedge clk_sys);
		io_enable <= 1'b0;
		fp_enable <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		tx_words.delete();
	endtask

	// core memory with a registered read
	always @(posedge clk_sys)
		ioctl_din <= mem_word(ioctl_addr);

	always @(posedge clk_sys) begin
		if (rst_n && ioctl_rd)
			rd_cnt++;
		if (rst_n && ioctl_wr) begin
			wr_cnt++;
			expect_eq("ioctl_download", 64'(ioctl_download), 64'(1'b1));
			if (wr_addr_exp.size() == 0) begin
				fail_now("ioctl_wr pulsed with no download word outstanding");
			end else begin
				expect_eq("ioctl_addr", 64'(ioctl_addr), 64'(wr_addr_exp.pop_front()));
				expect_eq("ioctl_dout", 64'(ioctl_dout), 64'(wr_data_exp.pop_front()));
			end
		end
	end

	assert property (@(posedge clk_sys) disable iff (!rst_n)
		(!io_enable && !fp_enable) |-> (io_dout == 16'h0))
	else fail_now($sformatf("error io_dout outside a frame: got 0x%0h, expected 0x0", io_dout));

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [15:0] cfg_word;
		logic [15:0] lo;
		logic [15:0] hi;
		logic [31:0] joy_exp [6];
		logic [63:0] st_exp;
		logic [63:0] req_exp;
		logic [15:0] data;
		logic [15:0] idx;
		logic [31:0] ext;
		logic [26:0] start;
		int          k;
		int          wr_before;
		int          rd_before;

		rst_n           = 1'b0;
		io_enable       = 1'b0;
		fp_enable       = 1'b0;
		io_strobe       = 1'b0;
		io_din          = '0;
		status_in       = '0;
		status_set      = 1'b0;
		status_menumask = '0;
		joy_raw         = '0;
		ioctl_din       = '0;
		repeat (16) @(posedge clk_sys);
		rst_n <= 1'b1;

		// config word and joysticks
		cfg_word = 16'(rand_bits(16));
		tx_words.push_back(hps_io_pkg::CFG);
		tx_words.push_back(cfg_word);
		run_frame(1'b0, 1'b1);
		expect_eq("buttons", 64'(buttons), 64'(cfg_word[1:0]));
		expect_eq("forced_scandoubler", 64'(forced_scandoubler), 64'(cfg_word[4]));
		expect_eq("direct_video", 64'(direct_video), 64'(cfg_word[10]));
		for (int n = 0; n < 6; n++) begin
			lo = 16'(rand_bits(16));
			hi = 16'(rand_bits(16));
			joy_exp[n] = {hi, lo};
			tx_words.push_back(joy_ops[n]);
			tx_words.push_back(lo);
			tx_words.push_back(hi);
			run_frame(1'b0, 1'b1);
			expect_eq($sformatf("joystick_%0d", n), 64'(joy_out(n)), 64'(joy_exp[n]));
		end

		// status write with the low slice first
		st_exp = rand_bits(64);
		tx_words.push_back(hps_io_pkg::STATUS);
		for (int s = 0; s < 4; s++)
			tx_words.push_back(st_exp[s * 16 +: 16]);
		run_frame(1'b0, 1'b1);
		expect_eq("status", status, st_exp);

		data = 16'(rand_bits(16));
		@(posedge clk_sys);
		joy_raw <= data;
		tx_words.push_back(hps_io_pkg::JOY_RAW);
		tx_words.push_back(16'h0000);
		run_frame(1'b0, 1'b1);
		expect_eq("io_dout joy_raw", 64'(rx_words[1]), 64'(data));

		data = 16'(rand_bits(16));
		@(posedge clk_sys);
		status_menumask <= data;
		tx_words.push_back(hps_io_pkg::MENU_MASK);
		tx_words.push_back(16'h0000);
		run_frame(1'b0, 1'b1);
		expect_eq("io_dout menu mask", 64'(rx_words[1]), 64'(data));

		// enough edges to wrap the tag count now and then
		k = 14 + int'(rand_bits(3));
		req_exp = '0;
		for (int p = 0; p < k; p++) begin
			req_exp = rand_bits(64);
			@(posedge clk_sys);
			status_in  <= req_exp;
			status_set <= 1'b1;
			@(posedge clk_sys);
			status_set <= 1'b0;
		end
		@(posedge clk_sys);
		status_in <= ~req_exp;
		tx_words.push_back(hps_io_pkg::STATUS_REQ);
		for (int s = 0; s < 4; s++)
			tx_words.push_back(16'h0000);
		run_frame(1'b0, 1'b1);
		expect_eq("io_dout request tag", 64'(rx_words[0]), 64'({8'h00, `HPS_ST_TAG, 4'(k)}));
		for (int s = 0; s < 4; s++)
			expect_eq($sformatf("io_dout request slice %0d", s), 64'(rx_words[1 + s]),
				64'(req_exp[s * 16 +: 16]));

		// download
		idx   = 16'(rand_bits(16));
		ext   = 32'(rand_bits(32));
		start = 27'(rand_bits(27));
		tx_words.push_back(hps_io_pkg::FILE_INDEX);
		tx_words.push_back(idx);
		run_frame(1'b1, 1'b0);
		tx_words.push_back(hps_io_pkg::FILE_INFO);
		tx_words.push_back(ext[31:16]);
		tx_words.push_back(ext[15:0]);
		run_frame(1'b1, 1'b0);
		tx_words.push_back(hps_io_pkg::FILE_TX);
		tx_words.push_back(16'h0001);
		tx_words.push_back(start[15:0]);
		tx_words.push_back({5'b0, start[26:16]});
		run_frame(1'b1, 1'b0);
		expect_eq("ioctl_download", 64'(ioctl_download), 64'(1'b1));
		expect_eq("ioctl_index", 64'(ioctl_index), 64'(idx));
		expect_eq("ioctl_file_ext", 64'(ioctl_file_ext), 64'(ext));

		wr_before = wr_cnt;
		tx_words.push_back(hps_io_pkg::FILE_TX_DAT);
		for (int n = 0; n < n_dl; n++) begin
			data = 16'(rand_bits(16));
			tx_words.push_back(data);
			wr_addr_exp.push_back(start + 27'(`HPS_ADDR_STEP * n));
			wr_data_exp.push_back(data);
		end
		run_frame(1'b1, 1'b0);
		expect_eq("ioctl_wr pulse count", 64'(wr_cnt - wr_before), 64'(n_dl));
		expect_eq("outstanding writes", 64'(wr_addr_exp.size()), 64'(0));

		tx_words.push_back(hps_io_pkg::FILE_TX);
		tx_words.push_back(16'h0000);
		run_frame(1'b1, 1'b0);
		expect_eq("ioctl_download", 64'(ioctl_download), 64'(1'b0));
		expect_eq("ioctl_addr", 64'(ioctl_addr), 64'(start + 27'(`HPS_ADDR_STEP * n_dl)));

		// upload from address zero
		rd_before = rd_cnt;
		tx_words.push_back(hps_io_pkg::FILE_TX);
		tx_words.push_back(`HPS_UPLOAD_KEY);
		run_frame(1'b1, 1'b0);
		expect_eq("ioctl_upload", 64'(ioctl_upload), 64'(1'b1));
		expect_eq("ioctl_rd pulse count", 64'(rd_cnt - rd_before), 64'(1));
		tx_words.push_back(hps_io_pkg::FILE_TX_DAT);
		for (int n = 0; n < n_ul; n++)
			tx_words.push_back(16'h0000);
		run_frame(1'b1, 1'b0);
		for (int n = 0; n < n_ul; n++)
			expect_eq($sformatf("io_dout upload word %0d", n), 64'(rx_words[1 + n]),
				64'(mem_word(27'(`HPS_ADDR_STEP * n))));
		expect_eq("ioctl_rd pulse count", 64'(rd_cnt - rd_before), 64'(1 + n_ul));
		tx_words.push_back(hps_io_pkg::FILE_TX);
		tx_words.push_back(16'h0000);
		run_frame(1'b1, 1'b0);
		expect_eq("ioctl_upload", 64'(ioctl_upload), 64'(1'b0));

		// both enables together so the file side owns the frame
		tx_words.push_back(hps_io_pkg::JOY0);
		tx_words.push_back(~joy_exp[0][15:0]);
		tx_words.push_back(~joy_exp[0][31:16]);
		run_frame(1'b1, 1'b1);
		for (int n = 0; n < 6; n++)
			expect_eq($sformatf("joystick_%0d", n), 64'(joy_out(n)), 64'(joy_exp[n]));
		data = ~idx;
		tx_words.push_back(hps_io_pkg::FILE_INDEX);
		tx_words.push_back(data);
		run_frame(1'b1, 1'b1);
		expect_eq("ioctl_index", 64'(ioctl_index), 64'(data));

		repeat (4) @(posedge clk_sys);
		$display("Simulation passed");
		$finish;
	end

endmodule

// File: build.f
+incdir+.
hps_io_pkg.sv
hps_word_if.sv
hps_bus_frame.sv
uio_regs.sv
fio_loader.sv
hps_io.sv
tb_hps_io.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the hps_io testbench with Verilator and runs it
# the run passes only when the pass message shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module tb_hps_io -o sim_hps_io &&
./obj_dir/sim_hps_io 2>&1 | tee /dev/stderr | grep -F "Simulation passed" > /dev/null &&
echo "run_sim: PASS" && exit 0 || { echo "run_sim: FAIL"; exit 1; }
